// ==== tb.f ====
+incdir+source
source/lfps_pkg.sv
source/lfps_send_select.sv
source/lfps_send_timer.sv
source/lfps_recv_classify.sv
source/lfps_top.sv
dv/lfps_chk.sv
dv/lfps_tb.sv

// ==== Makefile ====
# verilator build and run of the lfps testbench

all: run

obj_dir/Vlfps_tb: tb.f source/*.sv source/*.svh dv/*.sv
	verilator --binary --assert -Wno-fatal -f tb.f --top-module lfps_tb

run: obj_dir/Vlfps_tb
	./obj_dir/Vlfps_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Testbench passed" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module lfps_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== dv/lfps_trace.txt ====
# send:    1 req_mask(hex b0 poll b1 ping b2 u1 b3 u2lb b4 u3) training power_state pulse ack_delay
# receive: 2 burst_width idle_before event(hex b0 poll_u1 b1 ping b2 reset b3 u3)
# polling on P1 then on P0
1 01 0 1 8 41
1 01 0 0 8 41
# poll beats ping, then ping alone
1 03 0 2 8 41
1 02 0 1 3 201
# held off by training
1 01 1 3 8 41
# exit and wakeup bursts
1 04 0 1 20 21
1 08 0 2 30 31
1 10 0 0 60 61
1 1c 0 1 20 21
# polling pairs, single, in window, out of window, in window
2 8 20 0
2 8 30 1
2 8 60 0
2 8 35 1
# ping pairs
2 3 40 0
2 3 180 2
2 3 100 0
# warm reset and u3 wakeup
2 120 40 4
2 60 40 8
# widths outside every window clear the pairing
2 20 40 0
2 90 40 0
2 8 30 0

// ==== dv/lfps_tb.sv ====
//////////////////////////////////////////////////
// lfps layer testbench
// replays send requests and receive bursts from
// the trace and compares tx lines, ack and events
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lfps_tb;

	// receive events land 3 cycles after rx idle returns
	localparam int event_latency = 3;
	localparam int event_wait    = 8;
	localparam int train_hold    = 16;
	localparam int send_limit    = 400;

	logic       slow_clk;
	logic       lfps_send_reset_local;
	logic       send_poll;
	logic       send_ping;
	logic       send_u1;
	logic       send_u2lb;
	logic       send_u3;
	logic       training;
	logic [1:0] power_state;
	logic       rx_elecidle;
	logic       rx_valid;
	logic       tx_elecidle;
	logic       tx_detrx_lpbk;
	logic       send_ack;
	logic       recv_active;
	logic       recv_poll_u1;
	logic       recv_ping;
	logic       recv_reset;
	logic       recv_u3;

	// idle cycles already spent since the last rx burst
	int idle_done;

	lfps_top lfps_top_i (.*);

	always #4 slow_clk = !slow_clk;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			stop_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_outputs_idle();
		check_value("tx_elecidle", int'(tx_elecidle), 1);
		check_value("tx_detrx_lpbk", int'(tx_detrx_lpbk), 0);
		check_value("send_ack", int'(send_ack), 0);
		check_value("recv_active", int'(recv_active), 0);
		check_value("recv events", int'({recv_u3, recv_reset, recv_ping, recv_poll_u1}), 0);
	endtask

	// bit0 poll, bit1 ping, bit2 u1, bit3 u2lb, bit4 u3
	task automatic drive_requests(input logic [4:0] mask);
		send_poll <= mask[0];
		send_ping <= mask[1];
		send_u1   <= mask[2];
		send_u2lb <= mask[3];
		send_u3   <= mask[4];
	endtask

	//////////////////////////////////////////////////
	// send record
	//////////////////////////////////////////////////
	task automatic play_send(input int mask, input int train, input int pwr,
			input int exp_pulse, input int exp_ack);
		int   k;
		int   first_on;
		int   width;
		int   other;
		int   ack_at;
		logic on;
		logic off_line;
		k        = 0;
		first_on = -1;
		width    = 0;
		other    = 0;
		ack_at   = -1;
		@(posedge slow_clk);
		drive_requests(mask[4:0]);
		training    <= (train != 0);
		power_state <= pwr[1:0];
		// nothing may leave while training holds the request
		if (train != 0) begin
			repeat (train_hold) begin
				@(negedge slow_clk);
				check_outputs_idle();
			end
			@(posedge slow_clk);
			training <= 1'b0;
		end
		// k = 0 is the accept cycle
		while (ack_at < 0) begin
			@(negedge slow_clk);
			// P0 bursts on detect/loopback while others drop idle
			if (pwr == 0) begin
				on       = tx_detrx_lpbk;
				off_line = !tx_elecidle;
			end else begin
				on       = !tx_elecidle;
				off_line = tx_detrx_lpbk;
			end
			if (on) begin
				if (first_on < 0) begin
					first_on = k;
				end
				width++;
			end
			if (off_line) begin
				other++;
			end
			if (send_ack) begin
				ack_at = k;
			end
			k++;
			if (k > send_limit) begin
				stop_run("timeout waiting for send_ack after a send request");
			end
			@(posedge slow_clk);
			// request is a level and drops once taken
			if (k == 1) begin
				drive_requests(5'b0);
			end
		end
		check_value("tx pulse start", first_on, 1);
		check_value("tx pulse width", width, exp_pulse);
		check_value("unused tx line", other, 0);
		check_value("send_ack delay", ack_at, exp_ack);
	endtask

	//////////////////////////////////////////////////
	// receive record
	//////////////////////////////////////////////////
	task automatic play_burst(input int width, input int gap, input int exp_code);
		int k;
		int code;
		int active;
		int seen_at;
		code    = 0;
		active  = 0;
		seen_at = -1;
		if (gap < idle_done) begin
			stop_run("trace idle gap shorter than the event watch window");
		end
		repeat (gap - idle_done) begin
			@(posedge slow_clk);
			rx_elecidle <= 1'b1;
		end
		repeat (width) begin
			@(posedge slow_clk);
			rx_elecidle <= 1'b0;
		end
		@(posedge slow_clk);
		rx_elecidle <= 1'b1;
		// sync flops, burst end and output register
		for (k = 0; k < event_wait; k++) begin
			@(negedge slow_clk);
			if ({recv_u3, recv_reset, recv_ping, recv_poll_u1} != 4'b0) begin
				code    = code | int'({recv_u3, recv_reset, recv_ping, recv_poll_u1});
				seen_at = k;
			end
			if (recv_active) begin
				active++;
			end
		end
		idle_done = event_wait;
		check_value("recv event code", code, exp_code);
		check_value("recv_active pulses", active, (exp_code != 0) ? 1 : 0);
		if (exp_code != 0) begin
			check_value("recv event latency", seen_at, event_latency);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int    fd;
		int    rc;
		int    rtype;
		int    f1;
		int    f2;
		int    f3;
		int    f4;
		int    f5;
		int    records;
		string line;
		void'($urandom(11));
		records               = 0;
		idle_done             = 0;
		slow_clk              = 1'b0;
		lfps_send_reset_local = 1'b1;
		send_poll             = 1'b0;
		send_ping             = 1'b0;
		send_u1               = 1'b0;
		send_u2lb             = 1'b0;
		send_u3               = 1'b0;
		training              = 1'b0;
		power_state           = 2'd0;
		rx_elecidle           = 1'b1;
		rx_valid              = 1'b0;

		// reset for 8 cycles with outputs checked inside and after
		repeat (7) @(posedge slow_clk);
		@(negedge slow_clk);
		check_outputs_idle();
		@(posedge slow_clk);
		lfps_send_reset_local <= 1'b0;
		@(negedge slow_clk);
		check_outputs_idle();

		fd = $fopen("dv/lfps_trace.txt", "r");
		if (fd == 0) begin
			stop_run("cannot open the trace file dv/lfps_trace.txt");
		end
		while (!$feof(fd)) begin
			rc    = $fgets(line, fd);
			rtype = 0;
			if (rc > 0) begin
				rc = $sscanf(line, "%d", rtype);
			end
			if (rtype == 1) begin
				rc = $sscanf(line, "%d %h %d %d %d %d", rtype, f1, f2, f3, f4, f5);
				if (rc != 6) begin
					stop_run("malformed send record in the trace");
				end
				// random idle spacing between send records
				repeat ($urandom % 6) @(posedge slow_clk);
				play_send(f1, f2, f3, f4, f5);
				records++;
			end else if (rtype == 2) begin
				rc = $sscanf(line, "%d %d %d %h", rtype, f1, f2, f3);
				if (rc != 4) begin
					stop_run("malformed receive record in the trace");
				end
				play_burst(f1, f2, f3);
				records++;
			end
		end
		$fclose(fd);
		if (records == 0) begin
			stop_run("trace file held no records");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// ==== dv/lfps_chk.sv ====
//////////////////////////////////////////////////
// lfps top level checker
// assertions on tx lines, send ack and the
// receive event pulses, bound to the top level
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lfps_chk (
	input logic slow_clk,
	input logic lfps_send_reset_local,
	input logic tx_elecidle,
	input logic tx_detrx_lpbk,
	input logic send_ack,
	input logic recv_active,
	input logic recv_poll_u1,
	input logic recv_ping,
	input logic recv_reset,
	input logic recv_u3
);

	// ack is a one cycle strobe
	ack_single: assert property (@(posedge slow_clk) disable iff (lfps_send_reset_local)
		send_ack |=> !send_ack)
		else $error("send_ack high for two cycles");

	// detect/loopback only with electrical idle kept high
	tx_lines: assert property (@(posedge slow_clk)
		!(tx_detrx_lpbk && !tx_elecidle))
		else $error("tx_detrx_lpbk high while tx_elecidle low");

	// one burst classified at a time
	one_event: assert property (@(posedge slow_clk)
		$onehot0({recv_poll_u1, recv_ping, recv_reset, recv_u3}))
		else $error("more than one receive event at once");

	// quiet outputs once reset has been seen
	reset_quiet: assert property (@(posedge slow_clk)
		$past(lfps_send_reset_local) |-> (tx_elecidle && !tx_detrx_lpbk && !send_ack
			&& !recv_active && !recv_poll_u1 && !recv_ping && !recv_reset && !recv_u3))
		else $error("output active during reset");

endmodule

bind lfps_top lfps_chk lfps_chk_i (
	.slow_clk              (slow_clk),
	.lfps_send_reset_local (lfps_send_reset_local),
	.tx_elecidle           (tx_elecidle),
	.tx_detrx_lpbk         (tx_detrx_lpbk),
	.send_ack              (send_ack),
	.recv_active           (recv_active),
	.recv_poll_u1          (recv_poll_u1),
	.recv_ping             (recv_ping),
	.recv_reset            (recv_reset),
	.recv_u3               (recv_u3)
);

// ==== source/lfps_top.sv ====
//////////////////////////////////////////////////
// lfps layer top
// send request decode, send burst timer and
// receive classifier on slow_clk
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lfps_settings.svh"

module lfps_top (
	input  logic       slow_clk,
	input  logic       lfps_send_reset_local,
	// send requests
	input  logic       send_poll,
	input  logic       send_ping,
	input  logic       send_u1,
	input  logic       send_u2lb,
	input  logic       send_u3,
	input  logic       training,
	input  logic [1:0] power_state,
	// receiver pipe lines
	input  logic       rx_elecidle,
	input  logic       rx_valid,
	// transmitter pipe lines
	output logic       tx_elecidle,
	output logic       tx_detrx_lpbk,
	output logic       send_ack,
	// receive events
	output logic       recv_active,
	output logic       recv_poll_u1,
	output logic       recv_ping,
	output logic       recv_reset,
	output logic       recv_u3
);

	// decode to timer
	logic                   start;
	logic [`LFPS_CNT_W-1:0] pulse_len;
	logic [`LFPS_CNT_W-1:0] interval_len;

	lfps_send_select send_select_i (
		.send_poll    (send_poll),
		.send_ping    (send_ping),
		.send_u1      (send_u1),
		.send_u2lb    (send_u2lb),
		.send_u3      (send_u3),
		.training     (training),
		.start        (start),
		.pulse_len    (pulse_len),
		.interval_len (interval_len)
	);

	lfps_send_timer send_timer_i (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.start                 (start),
		.pulse_len             (pulse_len),
		.interval_len          (interval_len),
		.power_state           (power_state),
		.tx_elecidle           (tx_elecidle),
		.tx_detrx_lpbk         (tx_detrx_lpbk),
		.send_ack              (send_ack)
	);

	// receive path is independent of the send side
	lfps_recv_classify recv_classify_i (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.rx_elecidle           (rx_elecidle),
		.rx_valid              (rx_valid),
		.recv_active           (recv_active),
		.recv_poll_u1          (recv_poll_u1),
		.recv_ping             (recv_ping),
		.recv_reset            (recv_reset),
		.recv_u3               (recv_u3)
	);

endmodule

// ==== source/lfps_recv_classify.sv ====
//////////////////////////////////////////////////
// lfps receive classifier
// syncs rx lines, measures burst width and spacing,
// reports polling/u1, ping, warm reset or u3 wakeup
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lfps_settings.svh"

module lfps_recv_classify (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  logic rx_elecidle,
	input  logic rx_valid,
	output logic recv_active,
	output logic recv_poll_u1,
	output logic recv_ping,
	output logic recv_reset,
	output logic recv_u3
);

	// two flop synchronizers
	logic elecidle_1;
	logic elecidle_2;
	logic valid_1;
	logic valid_2;

	lfps_pkg::recv_state_t state;

	logic                   burst_on;
	logic                   burst_end;
	logic [`LFPS_CNT_W-1:0] width;
	logic [`LFPS_CNT_W-1:0] gap;

	// pairing memory
	logic poll_prev;
	logic ping_prev;

	// window hits at burst end
	logic hit_poll;
	logic hit_ping;
	logic hit_reset;
	logic hit_u3;
	logic gap_poll;
	logic gap_ping;

	// half-open window test
	function automatic logic in_win(input logic [`LFPS_CNT_W-1:0] v, input int lo, input int hi);
		return (int'(v) >= lo) && (int'(v) < hi);
	endfunction

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			elecidle_1 <= 1'b1;
			elecidle_2 <= 1'b1;
			valid_1    <= 1'b0;
			valid_2    <= 1'b0;
		end else begin
			{elecidle_2, elecidle_1} <= {elecidle_1, rx_elecidle};
			{valid_2, valid_1}       <= {valid_1, rx_valid};
		end
	end

	// lfps seen as squelch open with no valid data
	assign burst_on  = !elecidle_2 && !valid_2;
	assign burst_end = (state == lfps_pkg::RECV_BURST) && !burst_on;

	//////////////////////////////////////////////////
	// width and spacing
	//////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			state <= lfps_pkg::RECV_IDLE;
		end else begin
			case (state)
			lfps_pkg::RECV_IDLE: begin
				if (burst_on) begin
					state <= lfps_pkg::RECV_BURST;
				end
			end
			lfps_pkg::RECV_BURST: begin
				if (!burst_on) begin
					state <= lfps_pkg::RECV_IDLE;
				end
			end
			default: state <= lfps_pkg::RECV_IDLE;
			endcase
		end
	end

	// width counts burst cycles, first one included
	always_ff @(posedge slow_clk) begin
		if (state == lfps_pkg::RECV_IDLE) begin
			width <= 1;
		end else if (burst_on && width != '1) begin
			width <= width + 1'b1;
		end
	end

	// spacing from the previous burst end, saturating
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local || burst_end) begin
			gap <= '0;
		end else if (gap != '1) begin
			gap <= gap + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// classification
	//////////////////////////////////////////////////
	assign hit_poll  = in_win(width, `LFPS_POLL_MIN, `LFPS_POLL_MAX);
	assign hit_ping  = in_win(width, `LFPS_PING_MIN, `LFPS_PING_MAX);
	assign hit_reset = in_win(width, `LFPS_RESET_MIN, `LFPS_RESET_MAX);
	assign hit_u3    = in_win(width, `LFPS_U3_MIN, `LFPS_U3_MAX);
	assign gap_poll  = in_win(gap, `LFPS_POLL_GAP_MIN, `LFPS_POLL_GAP_MAX);
	assign gap_ping  = in_win(gap, `LFPS_PING_GAP_MIN, `LFPS_PING_GAP_MAX);

	always_ff @(posedge slow_clk) begin
		// event outputs are single cycle
		recv_active  <= 1'b0;
		recv_poll_u1 <= 1'b0;
		recv_ping    <= 1'b0;
		recv_reset   <= 1'b0;
		recv_u3      <= 1'b0;
		if (lfps_send_reset_local) begin
			poll_prev <= 1'b0;
			ping_prev <= 1'b0;
		end else if (burst_end) begin
			// any burst breaks an earlier pair
			poll_prev <= hit_poll;
			ping_prev <= hit_ping;
			// polling and ping only count as the second of a pair
			if (hit_poll && poll_prev && gap_poll) begin
				recv_poll_u1 <= 1'b1;
				recv_active  <= 1'b1;
			end
			if (hit_ping && ping_prev && gap_ping) begin
				recv_ping   <= 1'b1;
				recv_active <= 1'b1;
			end
			if (hit_reset) begin
				recv_reset  <= 1'b1;
				recv_active <= 1'b1;
			end
			if (hit_u3) begin
				recv_u3     <= 1'b1;
				recv_active <= 1'b1;
			end
		end
	end

endmodule

// ==== source/lfps_send_timer.sv ====
//////////////////////////////////////////////////
// lfps send burst timer
// runs one burst: pulse phase on the tx line chosen
// by power state, then the repeat interval, then ack
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lfps_settings.svh"

module lfps_send_timer (
	input  logic                   slow_clk,
	input  logic                   lfps_send_reset_local,
	input  logic                   start,
	input  logic [`LFPS_CNT_W-1:0] pulse_len,
	input  logic [`LFPS_CNT_W-1:0] interval_len,
	input  logic [1:0]             power_state,
	output logic                   tx_elecidle,
	output logic                   tx_detrx_lpbk,
	output logic                   send_ack
);

	lfps_pkg::send_state_t state;

	// pulse width remaining
	logic [`LFPS_CNT_W-1:0] pulse_cnt;
	// repeat interval remaining, counts through the pulse too
	logic [`LFPS_CNT_W-1:0] interval_cnt;

	logic in_p0;

	//////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			state <= lfps_pkg::SEND_IDLE;
		end else begin
			case (state)
			lfps_pkg::SEND_IDLE: begin
				// lengths only sampled here
				if (start) begin
					state <= lfps_pkg::SEND_PULSE;
				end
			end
			lfps_pkg::SEND_PULSE: begin
				// last pulse cycle
				if (pulse_cnt == 1) begin
					state <= lfps_pkg::SEND_INTERVAL;
				end
			end
			lfps_pkg::SEND_INTERVAL: begin
				// ack cycle, free again next cycle
				if (interval_cnt == 0) begin
					state <= lfps_pkg::SEND_IDLE;
				end
			end
			default: state <= lfps_pkg::SEND_IDLE;
			endcase
		end
	end

	// counters load on accept and run down together
	always_ff @(posedge slow_clk) begin
		if (state == lfps_pkg::SEND_IDLE) begin
			pulse_cnt    <= pulse_len;
			interval_cnt <= interval_len;
		end else begin
			if (state == lfps_pkg::SEND_PULSE) begin
				pulse_cnt <= pulse_cnt - 1'b1;
			end
			interval_cnt <= interval_cnt - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// tx lines and ack
	//////////////////////////////////////////////////
	assign in_p0 = (power_state == `LFPS_POWERDOWN_P0);

	// P0 bursts go out on detect/loopback, idle stays high
	// lower power states drop electrical idle instead
	assign tx_elecidle   = !((state == lfps_pkg::SEND_PULSE) && !in_p0);
	assign tx_detrx_lpbk = (state == lfps_pkg::SEND_PULSE) && in_p0;

	// one cycle at interval expiry
	assign send_ack = (state == lfps_pkg::SEND_INTERVAL) && (interval_cnt == 0);

endmodule

// ==== source/lfps_send_select.sv ====
//////////////////////////////////////////////////
// lfps send request decode
// picks one burst kind by fixed priority and looks
// up its pulse width and repeat interval
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lfps_settings.svh"

module lfps_send_select (
	input  logic                   send_poll,
	input  logic                   send_ping,
	input  logic                   send_u1,
	input  logic                   send_u2lb,
	input  logic                   send_u3,
	input  logic                   training,
	output logic                   start,
	output logic [`LFPS_CNT_W-1:0] pulse_len,
	output logic [`LFPS_CNT_W-1:0] interval_len
);

	localparam int cnt_w = `LFPS_CNT_W;

	lfps_pkg::burst_kind_t kind;

	// polling wins, then ping, u1, u2/loopback, u3
	always_comb begin
		kind = lfps_pkg::BURST_NONE;
		if (send_poll) begin
			kind = lfps_pkg::BURST_POLL;
		end else if (send_ping) begin
			kind = lfps_pkg::BURST_PING;
		end else if (send_u1) begin
			kind = lfps_pkg::BURST_U1EXIT;
		end else if (send_u2lb) begin
			kind = lfps_pkg::BURST_U2LB;
		end else if (send_u3) begin
			kind = lfps_pkg::BURST_U3WAKE;
		end
	end

	// held off for as long as training runs
	assign start = (kind != lfps_pkg::BURST_NONE) && !training;

	// pulse and interval lookup
	always_comb begin
		case (kind)
		lfps_pkg::BURST_POLL: begin
			pulse_len    = cnt_w'(`LFPS_POLL_PULSE);
			interval_len = cnt_w'(`LFPS_POLL_INTERVAL);
		end
		lfps_pkg::BURST_PING: begin
			pulse_len    = cnt_w'(`LFPS_PING_PULSE);
			interval_len = cnt_w'(`LFPS_PING_INTERVAL);
		end
		// exit bursts repeat at their own width
		lfps_pkg::BURST_U1EXIT: begin
			pulse_len    = cnt_w'(`LFPS_U1EXIT_PULSE);
			interval_len = cnt_w'(`LFPS_U1EXIT_PULSE);
		end
		lfps_pkg::BURST_U2LB: begin
			pulse_len    = cnt_w'(`LFPS_U2LB_PULSE);
			interval_len = cnt_w'(`LFPS_U2LB_PULSE);
		end
		lfps_pkg::BURST_U3WAKE: begin
			pulse_len    = cnt_w'(`LFPS_U3WAKE_PULSE);
			interval_len = cnt_w'(`LFPS_U3WAKE_PULSE);
		end
		default: begin
			pulse_len    = '0;
			interval_len = '0;
		end
		endcase
	end

endmodule

// ==== source/lfps_pkg.sv ====
//////////////////////////////////////////////////
// lfps shared types
// burst kinds and the send/receive fsm encodings
//////////////////////////////////////////////////
package lfps_pkg;

	// burst kinds, in send priority order
	typedef enum logic [2:0] {
		BURST_NONE    = 3'd0,
		BURST_POLL    = 3'd1,
		BURST_PING    = 3'd2,
		BURST_U1EXIT  = 3'd3,
		BURST_U2LB    = 3'd4,
		BURST_U3WAKE  = 3'd5
	} burst_kind_t;

	// send fsm
	typedef enum logic [1:0] {
		SEND_IDLE     = 2'd0,
		SEND_PULSE    = 2'd1,
		SEND_INTERVAL = 2'd2
	} send_state_t;

	// receive fsm
	typedef enum logic [1:0] {
		RECV_IDLE     = 2'd0,
		RECV_BURST    = 2'd1
	} recv_state_t;

endpackage

// ==== source/lfps_settings.svh ====
//////////////////////////////////////////////////
// lfps timing settings
// burst pulse and repeat counts for the send side,
// width and spacing windows for the receive side
// all counts in slow_clk cycles, scaled down
//////////////////////////////////////////////////
`ifndef LFPS_SETTINGS_SVH
`define LFPS_SETTINGS_SVH

// width of every duration counter
`define LFPS_CNT_W 12

// send pulse widths and repeat intervals
`define LFPS_POLL_PULSE 8
`define LFPS_POLL_INTERVAL 40
`define LFPS_PING_PULSE 3
`define LFPS_PING_INTERVAL 200
// exit and wakeup bursts repeat at their own width
`define LFPS_U1EXIT_PULSE 20
`define LFPS_U2LB_PULSE 30
`define LFPS_U3WAKE_PULSE 60

// receive width windows, min inclusive, max exclusive
`define LFPS_POLL_MIN 6
`define LFPS_POLL_MAX 12
`define LFPS_PING_MIN 2
`define LFPS_PING_MAX 5
`define LFPS_RESET_MIN 100
`define LFPS_RESET_MAX 200
`define LFPS_U3_MIN 45
`define LFPS_U3_MAX 80

// spacing windows between paired bursts
// measured from one burst end to the next
`define LFPS_POLL_GAP_MIN 30
`define LFPS_POLL_GAP_MAX 50
`define LFPS_PING_GAP_MIN 150
`define LFPS_PING_GAP_MAX 260

// pipe power state code for P0
`define LFPS_POWERDOWN_P0 2'd0

`endif
